/* verilog/com_pkg.sv */
package com_pkg;

    // block types carried in the upper nibble of every frame word.
    localparam logic [3:0] BTYPE_INIT = 4'h0;
    localparam logic [3:0] BTYPE_INFO = 4'h1;
    localparam logic [3:0] BTYPE_DATA = 4'hE;

    // data bits per line frame; start and stop bits are added around them.
    localparam int FRAME_BITS = 16;

    // One frame word, read either as a DATA block or as an INFO block.
    // Both views keep the block type in the same place.
    typedef union packed {
        struct packed {
            logic [3:0] btype;
            logic [3:0] seq;       // sequence number of this data block.
            logic [7:0] payload;
        } data;
        struct packed {
            logic [3:0] btype;
            logic [3:0] ack_seq;   // sequence number being acknowledged.
            logic [7:0] read_count;
        } info;
    } com_frame_u;

endpackage

/* verilog/com_link_if.sv */
interface com_link_if;

    logic       fs_com_send;  // controller asks for one frame on the line.
    logic       fd_com_send;  // serializer has finished that frame.
    logic       fs_com_read;  // deserializer holds a received frame.
    logic       fd_com_read;  // controller has taken it.
    logic [3:0] tx_btype;
    logic [3:0] rx_btype;

    modport ctrl (
        output fs_com_send,
        input  fd_com_send,
        input  fs_com_read,
        output fd_com_read,
        output tx_btype,
        input  rx_btype
    );

    // shared by the codec, the serializer and the deserializer.
    modport line (
        input  fs_com_send,
        output fd_com_send,
        output fs_com_read,
        input  fd_com_read,
        input  tx_btype,
        output rx_btype
    );

endinterface

/* verilog/com_cs.sv */
module com_cs #(
    parameter int REPLY_TIMEOUT = 400,
    parameter int SEND_TRIES    = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       fs_send,
    output logic       fd_send,
    output logic       fs_read,
    input  logic       fd_read,
    output logic       send_ok,
    output logic [3:0] rd_btype,
    output logic       load_send,
    output logic       read_taken,
    com_link_if.ctrl   link
);

    localparam int MAIN_IDLE = 0;
    localparam int MAIN_WAIT = 1;
    localparam int READ_IDLE = 2;
    localparam int READ_WAIT = 3;
    localparam int READ_WORK = 4;
    localparam int READ_DONE = 5;
    localparam int SEND_IDLE = 6;
    localparam int SEND_WAIT = 7;
    localparam int SEND_WORK = 8;
    localparam int SEND_DONE = 9;

    localparam int TW = $clog2(REPLY_TIMEOUT + 1);
    localparam int AW = $clog2(SEND_TRIES + 1);

    logic [9:0]    state;
    logic [9:0]    next_state;
    logic [TW-1:0] reply_timer;
    logic [AW-1:0] tries;
    logic          timed_out;
    logic          last_try;

    assign timed_out = state[SEND_WAIT] && (reply_timer == TW'(REPLY_TIMEOUT - 1));
    assign last_try  = (tries == AW'(SEND_TRIES - 1));

    assign fd_send          = state[SEND_DONE];
    assign fs_read          = state[READ_WAIT];
    assign link.fs_com_send = state[READ_DONE] || state[SEND_IDLE];
    assign link.fd_com_read = state[READ_WORK] || state[SEND_WORK];

    // a received frame wins over a pending send request.
    assign load_send  = state[MAIN_WAIT] && !link.fs_com_read && fs_send;
    assign read_taken = state[READ_WAIT] && fd_read;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= '0;
            state[MAIN_IDLE] <= 1'b1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = '0;
        case (1'b1)
            state[MAIN_IDLE]: next_state[MAIN_WAIT] = 1'b1;
            state[MAIN_WAIT]: begin
                if (link.fs_com_read) next_state[READ_IDLE] = 1'b1;
                else if (fs_send) next_state[SEND_IDLE] = 1'b1;
                else next_state[MAIN_WAIT] = 1'b1;
            end
            state[READ_IDLE]: next_state[READ_WAIT] = 1'b1;
            state[READ_WAIT]: begin
                if (fd_read) next_state[READ_WORK] = 1'b1;
                else next_state[READ_WAIT] = 1'b1;
            end
            state[READ_WORK]: begin
                if (!link.fs_com_read) next_state[READ_DONE] = 1'b1;
                else next_state[READ_WORK] = 1'b1;
            end
            state[READ_DONE]: begin
                if (link.fd_com_send) next_state[MAIN_WAIT] = 1'b1; // INFO reply is out.
                else next_state[READ_DONE] = 1'b1;
            end
            state[SEND_IDLE]: begin
                if (link.fd_com_send) next_state[SEND_WAIT] = 1'b1;
                else next_state[SEND_IDLE] = 1'b1;
            end
            state[SEND_WAIT]: begin
                if (link.fs_com_read) next_state[SEND_WORK] = 1'b1;
                else if (timed_out && last_try) next_state[SEND_DONE] = 1'b1;
                else if (timed_out) next_state[SEND_IDLE] = 1'b1;
                else next_state[SEND_WAIT] = 1'b1;
            end
            state[SEND_WORK]: begin
                if (!link.fs_com_read) next_state[SEND_DONE] = 1'b1;
                else next_state[SEND_WORK] = 1'b1;
            end
            state[SEND_DONE]: begin
                if (!fs_send) next_state[MAIN_IDLE] = 1'b1;
                else next_state[SEND_DONE] = 1'b1;
            end
            default: next_state[MAIN_IDLE] = 1'b1;
        endcase
    end

    // every attempt gets the full reply window.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) reply_timer <= '0;
        else if (state[SEND_WAIT]) reply_timer <= reply_timer + 1'b1;
        else reply_timer <= '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) tries <= '0;
        else if (load_send) tries <= '0;
        else if (timed_out && !last_try) tries <= tries + 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) send_ok <= 1'b0;
        else if (load_send) send_ok <= 1'b0;
        else if (state[SEND_WAIT] && link.fs_com_read) send_ok <= 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            link.tx_btype <= com_pkg::BTYPE_INIT;
        end else if (state[MAIN_WAIT]) begin
            if (link.fs_com_read) link.tx_btype <= com_pkg::BTYPE_INFO;
            else if (fs_send) link.tx_btype <= com_pkg::BTYPE_DATA;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) rd_btype <= com_pkg::BTYPE_INIT;
        else if (state[READ_IDLE]) rd_btype <= link.rx_btype;
    end

endmodule

/* verilog/com_frame_codec.sv */
module com_frame_codec (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          wr_data,
    input  logic                load_send,
    input  logic                read_taken,
    output com_pkg::com_frame_u tx_word,
    input  com_pkg::com_frame_u rx_word,
    output logic [7:0]          rd_data,
    output logic [7:0]          peer_count,
    com_link_if.line            link
);

    logic [7:0] tx_byte;
    logic [3:0] seq_num;
    logic [7:0] read_count;
    logic [3:0] ack_seq;

    always_ff @(posedge clk) begin
        if (load_send) tx_byte <= wr_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq_num    <= '0;
            read_count <= '0;
            ack_seq    <= '0;
        end else begin
            if (load_send) seq_num <= seq_num + 1'b1; // wraps modulo 16.
            if (read_taken) begin
                read_count <= read_count + 1'b1;
                ack_seq    <= rx_word.data.seq;
            end
        end
    end

    always_comb begin
        if (link.tx_btype == com_pkg::BTYPE_DATA) begin
            tx_word.data.btype   = link.tx_btype;
            tx_word.data.seq     = seq_num;
            tx_word.data.payload = tx_byte;
        end else begin
            tx_word.info.btype      = link.tx_btype;
            tx_word.info.ack_seq    = ack_seq;
            tx_word.info.read_count = read_count;
        end
    end

    assign link.rx_btype = rx_word.data.btype;
    assign rd_data       = rx_word.data.payload;

    // the far end's read count only means something in an INFO block.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            peer_count <= '0;
        end else if (link.fs_com_read && rx_word.info.btype == com_pkg::BTYPE_INFO) begin
            peer_count <= rx_word.info.read_count;
        end
    end

endmodule

/* verilog/com_tx.sv */
module com_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  com_pkg::com_frame_u tx_word,
    output logic                txd,
    com_link_if.line            link
);

    localparam int BW       = $clog2(CLKS_PER_BIT);
    localparam int STOP_BIT = com_pkg::FRAME_BITS + 1;

    logic                         busy;
    logic [BW-1:0]                bit_timer;
    logic [4:0]                   bit_cnt;
    logic [com_pkg::FRAME_BITS:0] shifter;
    logic                         start;
    logic                         bit_end;

    // a new frame waits until the previous done flag has been cleared.
    assign start   = link.fs_com_send && !busy && !link.fd_com_send;
    assign bit_end = (bit_timer == BW'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy             <= 1'b0;
            bit_timer        <= '0;
            bit_cnt          <= '0;
            txd              <= 1'b1;
            link.fd_com_send <= 1'b0;
        end else if (start) begin
            busy      <= 1'b1;
            bit_timer <= '0;
            bit_cnt   <= '0;
            txd       <= 1'b0; // start bit.
        end else if (busy) begin
            if (!bit_end) begin
                bit_timer <= bit_timer + 1'b1;
            end else begin
                bit_timer <= '0;
                if (bit_cnt == 5'(STOP_BIT)) begin
                    busy             <= 1'b0;
                    link.fd_com_send <= 1'b1;
                end else begin
                    txd     <= shifter[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else if (link.fd_com_send && !link.fs_com_send) begin
            link.fd_com_send <= 1'b0;
        end
    end

    // data goes out least significant bit first, with the stop bit on top.
    always_ff @(posedge clk) begin
        if (start) shifter <= {1'b1, tx_word};
        else if (busy && bit_end) shifter <= shifter >> 1;
    end

endmodule

/* verilog/com_rx.sv */
module com_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rxd,
    output com_pkg::com_frame_u rx_word,
    com_link_if.line            link
);

    localparam int BW       = $clog2(CLKS_PER_BIT);
    localparam int STOP_BIT = com_pkg::FRAME_BITS + 1;

    logic [1:0]                     rxd_sync;
    logic                           rxd_prev;
    logic                           busy;
    logic [BW-1:0]                  bit_timer;
    logic [4:0]                     bit_cnt;
    logic [com_pkg::FRAME_BITS-1:0] shifter;
    logic                           start_edge;
    logic                           mid_bit;
    logic                           holding;
    logic                           data_bit;
    logic                           stop_ok;

    assign start_edge = !busy && rxd_prev && !rxd_sync[1];
    assign mid_bit    = busy && (bit_timer == BW'(CLKS_PER_BIT / 2 - 1));
    assign holding    = link.fs_com_read || link.fd_com_read;
    assign data_bit   = (bit_cnt >= 5'd1) && (bit_cnt <= 5'(com_pkg::FRAME_BITS));

    // frames that end while the last one is still held are dropped here.
    assign stop_ok = mid_bit && (bit_cnt == 5'(STOP_BIT)) && rxd_sync[1] && !holding;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_sync <= 2'b11;
            rxd_prev <= 1'b1;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rxd_prev <= rxd_sync[1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            bit_timer <= '0;
            bit_cnt   <= '0;
        end else if (start_edge) begin
            busy      <= 1'b1;
            bit_timer <= '0;
            bit_cnt   <= '0;
        end else if (busy) begin
            if (bit_timer == BW'(CLKS_PER_BIT - 1)) bit_timer <= '0;
            else bit_timer <= bit_timer + 1'b1;
            if (mid_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
                // a line that is high again at mid start bit was only a glitch.
                if (bit_cnt == 5'd0 && rxd_sync[1]) busy <= 1'b0;
                else if (bit_cnt == 5'(STOP_BIT)) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) link.fs_com_read <= 1'b0;
        else if (stop_ok) link.fs_com_read <= 1'b1;
        else if (link.fs_com_read && link.fd_com_read) link.fs_com_read <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (mid_bit && data_bit) shifter <= {rxd_sync[1], shifter[com_pkg::FRAME_BITS-1:1]};
        if (stop_ok) rx_word <= shifter;
    end

endmodule

/* verilog/com_link_top.sv */
module com_link_top #(
    parameter int CLKS_PER_BIT  = 8,
    parameter int REPLY_TIMEOUT = 400,
    parameter int SEND_TRIES    = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       fs_send,
    output logic       fd_send,
    input  logic [7:0] wr_data,
    output logic       send_ok,
    output logic       fs_read,
    input  logic       fd_read,
    output logic [3:0] rd_btype,
    output logic [7:0] rd_data,
    output logic [7:0] peer_count,
    output logic       txd,
    input  logic       rxd
);

    com_link_if link ();

    com_pkg::com_frame_u tx_word;
    com_pkg::com_frame_u rx_word;
    logic                load_send;
    logic                read_taken;

    com_cs #(
        .REPLY_TIMEOUT(REPLY_TIMEOUT),
        .SEND_TRIES   (SEND_TRIES)
    ) u_cs (
        .clk       (clk),
        .rst       (rst),
        .fs_send   (fs_send),
        .fd_send   (fd_send),
        .fs_read   (fs_read),
        .fd_read   (fd_read),
        .send_ok   (send_ok),
        .rd_btype  (rd_btype),
        .load_send (load_send),
        .read_taken(read_taken),
        .link      (link.ctrl)
    );

    com_frame_codec u_codec (
        .clk       (clk),
        .rst       (rst),
        .wr_data   (wr_data),
        .load_send (load_send),
        .read_taken(read_taken),
        .tx_word   (tx_word),
        .rx_word   (rx_word),
        .rd_data   (rd_data),
        .peer_count(peer_count),
        .link      (link.line)
    );

    com_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk    (clk),
        .rst    (rst),
        .tx_word(tx_word),
        .txd    (txd),
        .link   (link.line)
    );

    com_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk    (clk),
        .rst    (rst),
        .rxd    (rxd),
        .rx_word(rx_word),
        .link   (link.line)
    );

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* dv/com_tb.sv */
module com_tb;

    localparam int CLKS_PER_BIT  = 8;
    localparam int REPLY_TIMEOUT = 400;
    localparam int SEND_TRIES    = 3;
    localparam int RANDOM_SENDS  = 13;

    // one line frame is a start bit, the data bits and a stop bit.
    localparam int FRAME_CYCLES     = (com_pkg::FRAME_BITS + 2) * CLKS_PER_BIT;
    localparam int ROUNDTRIP_CYCLES = 2 * FRAME_CYCLES + 64;
    localparam int RETRY_CYCLES     = SEND_TRIES * (FRAME_CYCLES + REPLY_TIMEOUT) + 64;
    localparam int RUN_CYCLES       = 16 + ROUNDTRIP_CYCLES + RETRY_CYCLES + ROUNDTRIP_CYCLES
                                    + ROUNDTRIP_CYCLES + 3 * FRAME_CYCLES
                                    + RANDOM_SENDS * ROUNDTRIP_CYCLES;
    localparam int CYCLE_LIMIT      = RUN_CYCLES * 5 / 4; // 25% margin.

    logic       clk;
    logic       rst;
    logic       fs_send;
    logic       fd_send;
    logic [7:0] wr_data;
    logic       send_ok;
    logic       fs_read;
    logic       fd_read;
    logic [3:0] rd_btype;
    logic [7:0] rd_data;
    logic [7:0] peer_count;
    logic       txd;
    logic       rxd;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    tb_clk_gen #(.PERIOD(10), .RESET_CYCLES(2)) u_clk_gen (
        .clk(clk),
        .rst(rst)
    );

    com_link_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .REPLY_TIMEOUT(REPLY_TIMEOUT),
        .SEND_TRIES   (SEND_TRIES)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .fs_send   (fs_send),
        .fd_send   (fd_send),
        .wr_data   (wr_data),
        .send_ok   (send_ok),
        .fs_read   (fs_read),
        .fd_read   (fd_read),
        .rd_btype  (rd_btype),
        .rd_data   (rd_data),
        .peer_count(peer_count),
        .txd       (txd),
        .rxd       (rxd)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input string field,
                                 input logic [15:0] expected, input logic [15:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("Error: %s %s expected 0x%0h actual 0x%0h", name, field, expected, actual);
        end
    endtask

    task automatic require_true(input string name, input bit cond, input string what);
        checks++;
        assert (cond)
        else begin
            errors++;
            $display("%s: %s", name, what);
        end
    endtask

    // the far end transmitter sends a start bit, the data LSB first and then the given stop bit.
    task automatic drive_frame(input logic [15:0] word, input logic stop_bit);
        logic [17:0] bits;
        int          i;
        bits = {stop_bit, word, 1'b0};
        for (i = 0; i < 18; i++) begin
            @(posedge clk);
            rxd <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        rxd <= 1'b1;
    endtask

    // the far end receiver samples txd in the middle of each bit.
    task automatic capture_frame(input int wait_limit, output logic [15:0] word, output bit ok);
        int   n;
        int   i;
        logic start_level;
        logic stop_level;
        n    = 0;
        word = '0;
        ok   = 1'b0;
        do begin
            @(posedge clk);
            n++;
        end while (txd !== 1'b0 && n < wait_limit);
        if (txd === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(posedge clk);
            start_level = txd;
            for (i = 0; i < com_pkg::FRAME_BITS; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                word[i] = txd;
            end
            repeat (CLKS_PER_BIT) @(posedge clk);
            stop_level = txd;
            ok = (start_level === 1'b0) && (stop_level === 1'b1);
        end
    endtask

    task automatic wait_fd_send(input logic level, input int limit, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (n < limit && !ok) begin
            @(posedge clk);
            n++;
            if (fd_send === level) ok = 1'b1;
        end
    endtask

    task automatic wait_fs_read(input logic level, input int limit, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (n < limit && !ok) begin
            @(posedge clk);
            n++;
            if (fs_read === level) ok = 1'b1;
        end
    endtask

    task automatic send_with_reply(input string name, input logic [7:0] data,
                                   input logic [3:0] seq, input logic [7:0] count);
        com_pkg::com_frame_u word;
        com_pkg::com_frame_u reply;
        bit                  ok;
        fs_send <= 1'b1;
        wr_data <= data;
        capture_frame(64, word, ok);
        require_true(name, ok, "no well formed frame appeared on txd");
        compare_value(name, "btype", com_pkg::BTYPE_DATA, word.data.btype);
        compare_value(name, "seq", seq, word.data.seq);
        compare_value(name, "payload", data, word.data.payload);
        reply                 = '0;
        reply.info.btype      = com_pkg::BTYPE_INFO;
        reply.info.ack_seq    = seq;
        reply.info.read_count = count;
        drive_frame(reply, 1'b1);
        wait_fd_send(1'b1, REPLY_TIMEOUT, ok);
        require_true(name, ok, "fd_send did not rise after the INFO reply");
        compare_value(name, "send_ok", 1, send_ok);
        compare_value(name, "peer_count", count, peer_count);
        fs_send <= 1'b0;
        wait_fd_send(1'b0, 16, ok);
        require_true(name, ok, "fd_send stayed high after fs_send fell");
    endtask

    task automatic reset_values();
        compare_value("reset_state", "txd", 1, txd);
        compare_value("reset_state", "fd_send", 0, fd_send);
        compare_value("reset_state", "fs_read", 0, fs_read);
        compare_value("reset_state", "send_ok", 0, send_ok);
        compare_value("reset_state", "peer_count", 0, peer_count);
    endtask

    task automatic send_without_reply();
        com_pkg::com_frame_u word;
        logic [7:0]          data;
        bit                  ok;
        bit                  extra;
        int                  t;
        data = 8'($urandom);
        fs_send <= 1'b1;
        wr_data <= data;
        for (t = 0; t < SEND_TRIES; t++) begin
            capture_frame(REPLY_TIMEOUT + FRAME_CYCLES, word, ok);
            require_true("send_without_reply", ok, "an expected retry frame never appeared");
            compare_value("send_without_reply", "btype", com_pkg::BTYPE_DATA, word.data.btype);
            compare_value("send_without_reply", "seq", 4'd2, word.data.seq);
            compare_value("send_without_reply", "payload", data, word.data.payload);
        end
        extra = 1'b0;
        ok    = 1'b0;
        for (t = 0; t < REPLY_TIMEOUT + 64 && !ok; t++) begin
            @(posedge clk);
            if (txd === 1'b0) extra = 1'b1; // a start bit here is one try too many.
            if (fd_send === 1'b1) ok = 1'b1;
        end
        require_true("send_without_reply", ok, "fd_send did not rise after the last timeout");
        require_true("send_without_reply", !extra, "more frames went out than the try limit");
        compare_value("send_without_reply", "send_ok", 0, send_ok);
        fs_send <= 1'b0;
        wait_fd_send(1'b0, 16, ok);
        require_true("send_without_reply", ok, "fd_send stayed high after fs_send fell");
        send_with_reply("send_without_reply", 8'($urandom), 4'd3, 8'd9);
    endtask

    task automatic receive_frame();
        com_pkg::com_frame_u word;
        com_pkg::com_frame_u reply;
        bit                  ok;
        bit                  ok_reply;
        bit                  ok_drop;
        word              = '0;
        word.data.btype   = com_pkg::BTYPE_DATA;
        word.data.seq     = 4'd7;
        word.data.payload = 8'hA5;
        drive_frame(word, 1'b1);
        wait_fs_read(1'b1, FRAME_CYCLES, ok);
        require_true("receive", ok, "fs_read did not rise for a received frame");
        compare_value("receive", "rd_btype", com_pkg::BTYPE_DATA, rd_btype);
        compare_value("receive", "rd_data", 8'hA5, rd_data);
        // a DATA block leaves the far end's read count from the last INFO block alone.
        compare_value("receive", "peer_count", 8'd9, peer_count);
        fork
            capture_frame(64, reply, ok_reply);
            begin
                fd_read <= 1'b1;
                wait_fs_read(1'b0, 16, ok_drop);
                fd_read <= 1'b0;
            end
        join
        require_true("receive", ok_drop, "fs_read stayed high after fd_read");
        require_true("receive", ok_reply, "no INFO reply appeared on txd");
        compare_value("receive", "btype", com_pkg::BTYPE_INFO, reply.info.btype);
        compare_value("receive", "ack_seq", 4'd7, reply.info.ack_seq);
        compare_value("receive", "read_count", 8'd1, reply.info.read_count);
    endtask

    task automatic reject_broken_frame();
        com_pkg::com_frame_u word;
        bit                  seen;
        int                  n;
        word              = '0;
        word.data.btype   = com_pkg::BTYPE_DATA;
        word.data.seq     = 4'd2;
        word.data.payload = 8'h5A;
        drive_frame(word, 1'b0);
        seen = 1'b0;
        for (n = 0; n < 2 * FRAME_CYCLES; n++) begin
            @(posedge clk);
            if (fs_read === 1'b1) seen = 1'b1;
        end
        require_true("broken_frame", !seen, "fs_read rose for a frame whose stop bit was 0");
    endtask

    task automatic send_random_bytes();
        logic [3:0] seq;
        int         i;
        seq = 4'd3; // last sequence number used so far.
        for (i = 0; i < RANDOM_SENDS; i++) begin
            seq = seq + 4'd1;
            send_with_reply("random_bytes", 8'($urandom), seq, 8'(i + 16));
        end
    endtask

    initial begin
        fs_send = 1'b0;
        wr_data = 8'h00;
        fd_read = 1'b0;
        rxd     = 1'b1;
        void'($urandom(18));
        wait (rst === 1'b0);
        @(posedge clk);
        reset_values();
        send_with_reply("send_with_reply", 8'h3C, 4'd1, 8'd5);
        send_without_reply();
        receive_frame();
        reject_broken_frame();
        send_random_bytes();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
verilog/com_pkg.sv
verilog/com_link_if.sv
verilog/com_cs.sv
verilog/com_frame_codec.sv
verilog/com_tx.sv
verilog/com_rx.sv
verilog/com_link_top.sv
dv/tb_clk_gen.sv
dv/com_tb.sv

/* Bender.yml */
package:
  name: com_link

sources:
  - verilog/com_pkg.sv
  - verilog/com_link_if.sv
  - verilog/com_cs.sv
  - verilog/com_frame_codec.sv
  - verilog/com_tx.sv
  - verilog/com_rx.sv
  - verilog/com_link_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/com_tb.sv
